//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal -j 0
TOP       ?= tb_core_complex
FILELIST  ?= core_complex.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/core_complex_cases.txt
# A tgt id op arga argb exp_id exp_data   offload case, op 0 read 1 write, all hex
# D addr write wdata exp_port             data case, port 1 TCDM 0 SoC, all hex
A 1 03 1 cafe0001 00000009 00 00000000
A 1 04 0 00000000 00000009 04 cafe0001
A 1 05 0 00000000 00000001 05 00000000
A 1 06 1 12345678 00000014 00 00000000
A 1 07 0 00000000 00000014 07 00000000
A 1 08 0 00000000 00000004 08 00000000
A 1 09 1 0badf00d 0000001c 00 00000000
A 1 0a 0 00000000 0000001c 0a 00000000
A 1 0b 0 00000000 0000000c 0b 00000000
A 0 11 0 00001000 00000234 11 00001234
A 0 12 1 ffffffff 00000002 12 00000001
A 1 13 1 00000077 00000000 00 00000000
A 0 14 0 10000000 00000001 14 10000001
A 1 15 0 00000000 00000000 15 00000077
A 0 16 0 00000005 00000006 16 0000000b
A 1 17 0 00000000 00000109 17 cafe0001
D 00100000 0 00000000 1
D 0011fffc 0 00000000 1
D 00120000 0 00000000 0
D 000ffffc 0 00000000 0
D 00100040 1 deadbeef 1
D 80000000 1 01234567 0
D 00100100 0 00000000 1
D 40000010 0 00000000 0
D 00100104 0 00000000 1
D 40000014 0 00000000 0
D 00100108 0 00000000 1
D 40000018 0 00000000 0

//--- bench/tb_core_complex.sv
`timescale 1ns/1ps

// Core complex testbench
// Plays the core on the offload and data ports, models the accelerator
// and both memories, and checks all responses against a case file
module tb_core_complex;

  import cc_pkg::*;

  localparam int    CyclesPerCase = 200;
  localparam data_t TcdmPattern   = 32'h5a5a_0f0f;
  localparam data_t SocPattern    = 32'hc3c3_f0f0;

  integer      seed = 77;
  logic [31:0] rnd;

  logic     clk_i               = 1'b0;
  logic     rst_ni              = 1'b1;
  addr_t    tcdm_base_i         = 32'h0010_0000;
  acc_req_t acc_req_i           = '0;
  logic     acc_req_valid_i     = 1'b0;
  logic     acc_req_ready_o;
  acc_rsp_t acc_rsp_o;
  logic     acc_rsp_valid_o;
  logic     acc_rsp_ready_i     = 1'b0;
  acc_req_t acc_ext_req_o;
  logic     acc_ext_req_valid_o;
  logic     acc_ext_req_ready_i = 1'b0;
  acc_rsp_t acc_ext_rsp_i       = '0;
  logic     acc_ext_rsp_valid_i = 1'b0;
  logic     acc_ext_rsp_ready_o;
  dreq_t    data_req_i          = '0;
  logic     data_req_valid_i    = 1'b0;
  logic     data_req_ready_o;
  drsp_t    data_rsp_o;
  logic     data_rsp_valid_o;
  logic     data_rsp_ready_i    = 1'b0;
  dreq_t    tcdm_req_o, soc_req_o;
  logic     tcdm_req_valid_o, tcdm_req_ready_i, tcdm_rsp_valid_i, tcdm_rsp_ready_o;
  logic     soc_req_valid_o, soc_req_ready_i, soc_rsp_valid_i, soc_rsp_ready_o;
  drsp_t    tcdm_rsp_i, soc_rsp_i;
  logic     tcdm_go             = 1'b0;
  logic     soc_go              = 1'b0;

  // Cases from the file and outstanding expected responses
  acc_req_t  acc_cases [$];
  acc_rsp_t  acc_exp [$];
  dreq_t     data_cases [$];
  port_sel_t data_port [$];
  acc_rsp_t  ext_exp_q [$];
  acc_rsp_t  cfg_exp_q [$];
  drsp_t     data_exp_q [$];
  int        n_acc        = 0;
  int        n_data       = 0;
  int        acc_done     = 0;
  int        data_done    = 0;
  logic      cases_loaded = 1'b0;

  always #5 clk_i = ~clk_i;

  core_complex u_core_complex (
    .clk_i, .rst_ni, .tcdm_base_i,
    .acc_req_i, .acc_req_valid_i, .acc_req_ready_o,
    .acc_rsp_o, .acc_rsp_valid_o, .acc_rsp_ready_i,
    .acc_ext_req_o, .acc_ext_req_valid_o, .acc_ext_req_ready_i,
    .acc_ext_rsp_i, .acc_ext_rsp_valid_i, .acc_ext_rsp_ready_o,
    .data_req_i, .data_req_valid_i, .data_req_ready_o,
    .data_rsp_o, .data_rsp_valid_o, .data_rsp_ready_i,
    .tcdm_req_o, .tcdm_req_valid_o, .tcdm_req_ready_i,
    .tcdm_rsp_i, .tcdm_rsp_valid_i, .tcdm_rsp_ready_o,
    .soc_req_o, .soc_req_valid_o, .soc_req_ready_i,
    .soc_rsp_i, .soc_rsp_valid_i, .soc_rsp_ready_o
  );

  mem_port_model u_tcdm_model (
    .clk_i, .rst_ni, .pattern_i(TcdmPattern), .go_i(tcdm_go),
    .req_i(tcdm_req_o), .req_valid_i(tcdm_req_valid_o), .req_ready_o(tcdm_req_ready_i),
    .rsp_o(tcdm_rsp_i), .rsp_valid_o(tcdm_rsp_valid_i), .rsp_ready_i(tcdm_rsp_ready_o)
  );

  mem_port_model u_soc_model (
    .clk_i, .rst_ni, .pattern_i(SocPattern), .go_i(soc_go),
    .req_i(soc_req_o), .req_valid_i(soc_req_valid_o), .req_ready_o(soc_req_ready_i),
    .rsp_o(soc_rsp_i), .rsp_valid_o(soc_rsp_valid_i), .rsp_ready_i(soc_rsp_ready_o)
  );

  // --------------------------------------------------------------------------
  // Failure and compare tasks
  // --------------------------------------------------------------------------
  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_acc_req(input string name, input acc_req_t got, input acc_req_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_acc_rsp(input string name, input acc_rsp_t got, input acc_rsp_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_dreq(input string name, input dreq_t got, input dreq_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_drsp(input string name, input drsp_t got, input drsp_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_port(input string name, input port_sel_t got, input port_sel_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // --------------------------------------------------------------------------
  // Case file
  // --------------------------------------------------------------------------
  task automatic load_cases();
    integer      fd;
    integer      n;
    logic [7:0]  kind;
    string       line;
    logic [31:0] f [7];
    acc_req_t    areq;
    acc_rsp_t    arsp;
    dreq_t       dreq;
    fd = $fopen("bench/core_complex_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the case file");
      abort_run();
    end else begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, " %c", kind);
        if (n != 1) break;
        if (kind == "#") begin
          n = $fgets(line, fd);
        end else if (kind == "A") begin
          n = $fscanf(fd, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
          if (n != 7) begin
            $display("Malformed offload case in the case file");
            abort_run();
          end
          areq.tgt   = f[0][0];
          areq.id    = acc_id_t'(f[1]);
          areq.op    = cfg_op_e'(f[2][0]);
          areq.arga  = f[3];
          areq.argb  = f[4];
          arsp.id    = acc_id_t'(f[5]);
          arsp.data  = f[6];
          arsp.error = 1'b0;
          acc_cases.push_back(areq);
          acc_exp.push_back(arsp);
        end else if (kind == "D") begin
          n = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]);
          if (n != 4) begin
            $display("Malformed data case in the case file");
            abort_run();
          end
          dreq.addr  = f[0];
          dreq.write = f[1][0];
          dreq.wdata = f[2];
          dreq.strb  = '1;
          data_cases.push_back(dreq);
          data_port.push_back(port_sel_t'(f[3][0]));
        end else begin
          $display("Unknown case kind in the case file");
          abort_run();
        end
      end
      $fclose(fd);
      n_acc  = acc_cases.size();
      n_data = data_cases.size();
    end
  endtask

  // --------------------------------------------------------------------------
  // Core drivers
  // --------------------------------------------------------------------------
  task automatic drive_offload();
    for (int i = 0; i < n_acc; i++) begin
      if (acc_cases[i].tgt == 1'b0) begin
        ext_exp_q.push_back(acc_exp[i]);
      end else begin
        cfg_exp_q.push_back(acc_exp[i]);
      end
      acc_req_i       <= acc_cases[i];
      acc_req_valid_i <= 1'b1;
      @(posedge clk_i);
      while (!acc_req_ready_o) @(posedge clk_i);
    end
    acc_req_valid_i <= 1'b0;
  endtask

  task automatic drive_data();
    drsp_t exp;
    for (int i = 0; i < n_data; i++) begin
      // Memory models answer reads with the address scrambled per port
      exp.error = 1'b0;
      exp.data  = data_cases[i].write ? '0 : data_cases[i].addr ^
                  ((data_port[i] == PortTcdm) ? TcdmPattern : SocPattern);
      data_exp_q.push_back(exp);
      data_req_i       <= data_cases[i];
      data_req_valid_i <= 1'b1;
      @(posedge clk_i);
      while (!data_req_ready_o) @(posedge clk_i);
      if (tcdm_req_valid_o == soc_req_valid_o) begin
        $display("Data request was not sent to exactly one port");
        abort_run();
      end else if (tcdm_req_valid_o) begin
        check_port("data port", PortTcdm, data_port[i]);
        check_dreq("tcdm_req_o", tcdm_req_o, data_cases[i]);
      end else begin
        check_port("data port", PortSoc, data_port[i]);
        check_dreq("soc_req_o", soc_req_o, data_cases[i]);
      end
    end
    data_req_valid_i <= 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Models and monitors
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin
    rnd = $random(seed);
    acc_rsp_ready_i  <= rnd[0] | rnd[1];
    data_rsp_ready_i <= rnd[2] | rnd[3];
    tcdm_go          <= rnd[4];
    soc_go           <= rnd[5] & rnd[6];
  end

  // Accelerator answers one request at a time with the sum of its operands
  always @(posedge clk_i) begin
    if (rst_ni) begin
      acc_ext_req_ready_i <= 1'b1;
      acc_ext_rsp_valid_i <= 1'b0;
    end else if (acc_ext_req_valid_o && acc_ext_req_ready_i) begin
      check_acc_req("acc_ext_req_o", acc_ext_req_o, acc_req_i);
      acc_ext_rsp_i.id    <= acc_ext_req_o.id;
      acc_ext_rsp_i.data  <= acc_ext_req_o.arga + acc_ext_req_o.argb;
      acc_ext_rsp_i.error <= 1'b0;
      acc_ext_rsp_valid_i <= 1'b1;
      acc_ext_req_ready_i <= 1'b0;
    end else if (acc_ext_rsp_valid_i && acc_ext_rsp_ready_o) begin
      acc_ext_rsp_valid_i <= 1'b0;
      acc_ext_req_ready_i <= 1'b1;
    end
  end

  always @(posedge clk_i) begin
    if (!rst_ni && acc_rsp_valid_o && acc_rsp_ready_i) begin
      if (acc_ext_rsp_valid_i && acc_ext_rsp_ready_o) begin
        if (ext_exp_q.size() == 0) begin
          $display("Accelerator response without a pending request");
          abort_run();
        end else begin
          check_acc_rsp("acc_rsp_o", acc_rsp_o, ext_exp_q[0]);
          ext_exp_q.delete(0);
          acc_done++;
        end
      end else if (cfg_exp_q.size() == 0) begin
        $display("Configuration response without a pending request");
        abort_run();
      end else begin
        check_acc_rsp("acc_rsp_o", acc_rsp_o, cfg_exp_q[0]);
        cfg_exp_q.delete(0);
        acc_done++;
      end
    end
  end

  always @(posedge clk_i) begin
    if (!rst_ni && data_rsp_valid_o && data_rsp_ready_i) begin
      if (data_exp_q.size() == 0) begin
        $display("Data response without a pending request");
        abort_run();
      end else begin
        check_drsp("data_rsp_o", data_rsp_o, data_exp_q[0]);
        data_exp_q.delete(0);
        data_done++;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Sequence and watchdog
  // --------------------------------------------------------------------------
  initial begin
    load_cases();
    cases_loaded = 1'b1;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b0;
    @(posedge clk_i);
    fork
      drive_offload();
      drive_data();
    join
    wait (acc_done == n_acc && data_done == n_data);
    repeat (5) @(posedge clk_i);
    // Every expected response is in, so nothing may still be offered
    if (!acc_rsp_valid_o && !data_rsp_valid_o) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("A response is still offered after all cases completed");
      abort_run();
    end
  end

  initial begin
    wait (cases_loaded);
    repeat (CyclesPerCase * (n_acc + n_data) + 20) @(posedge clk_i);
    $display("Timeout: not all cases completed in the allowed cycles");
    abort_run();
  end

endmodule

// Memory port model
// Accepts every request at once and answers in order after a random delay
module mem_port_model (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  cc_pkg::data_t pattern_i,
  input  logic          go_i,
  input  cc_pkg::dreq_t req_i,
  input  logic          req_valid_i,
  output logic          req_ready_o,
  output cc_pkg::drsp_t rsp_o,
  output logic          rsp_valid_o,
  input  logic          rsp_ready_i
);

  import cc_pkg::*;

  data_t pending_q [$];
  drsp_t rsp_q   = '0;
  logic  valid_q = 1'b0;

  assign req_ready_o = 1'b1;
  assign rsp_o       = rsp_q;
  assign rsp_valid_o = valid_q;

  always @(posedge clk_i) begin
    if (rst_ni) begin
      pending_q.delete();
      valid_q <= 1'b0;
    end else begin
      if (req_valid_i) begin
        pending_q.push_back(req_i.write ? '0 : (req_i.addr ^ pattern_i));
      end
      if (valid_q && rsp_ready_i) begin
        pending_q.delete(0);
        valid_q <= 1'b0;
      end else if (!valid_q && go_i && pending_q.size() > 0) begin
        rsp_q.data  <= pending_q[0];
        rsp_q.error <= 1'b0;
        valid_q     <= 1'b1;
      end
    end
  end

endmodule

//--- core_complex.f
rtl/cc_pkg.sv
rtl/offload_xbar.sv
rtl/ssr_cfg_unit.sv
rtl/data_router.sv
rtl/core_complex.sv
bench/tb_core_complex.sv

//--- rtl/cc_pkg.sv
// Core complex shared definitions
// Widths, request/response payloads and fixed sizes of the offload
// crossbar, the stream-register configuration unit and the data router
package cc_pkg;

  // --------------------------------------------------------------------------
  // Widths and sizes
  // --------------------------------------------------------------------------
  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned StrbWidth     = DataWidth / 8;
  localparam int unsigned AccIdWidth    = 5;

  // External accelerator and configuration unit
  localparam int unsigned NumAccTargets = 2;

  // Stream-register configuration space
  localparam int unsigned NumSsrs        = 2;
  localparam int unsigned NumCfgRegs     = 4;
  localparam int unsigned CfgRegBits     = 3;
  localparam int unsigned CfgSsrBits     = 2;
  localparam int unsigned SsrIdxWidth    = $clog2(NumSsrs);
  localparam int unsigned CfgRegIdxWidth = $clog2(NumCfgRegs);

  // TCDM window is 2**TcdmAddrWidth bytes, naturally aligned
  localparam int unsigned TcdmAddrWidth = 17;

  // Data requests in flight in the router
  localparam int unsigned RespDepth    = 4;
  localparam int unsigned RespPtrWidth = $clog2(RespDepth);
  localparam int unsigned RespCntWidth = $clog2(RespDepth + 1);

  // --------------------------------------------------------------------------
  // Scalar types
  // --------------------------------------------------------------------------
  typedef logic [AddrWidth-1:0]             addr_t;
  typedef logic [DataWidth-1:0]             data_t;
  typedef logic [StrbWidth-1:0]             strb_t;
  typedef logic [AccIdWidth-1:0]            acc_id_t;
  // 0 selects the external accelerator, 1 the configuration unit
  typedef logic                             acc_tgt_t;
  // Upper bits pick the register, lower bits the stream register
  typedef logic [CfgRegBits+CfgSsrBits-1:0] cfg_addr_t;
  // 0 selects SoC, 1 selects TCDM
  typedef logic                             port_sel_t;

  localparam port_sel_t PortSoc  = 1'b0;
  localparam port_sel_t PortTcdm = 1'b1;

  typedef enum logic {
    CFG_READ  = 1'b0,
    CFG_WRITE = 1'b1
  } cfg_op_e;

  // --------------------------------------------------------------------------
  // Payloads
  // --------------------------------------------------------------------------
  // arga carries write data, argb the configuration word address
  typedef struct packed {
    acc_tgt_t tgt;
    acc_id_t  id;
    cfg_op_e  op;
    data_t    arga;
    data_t    argb;
  } acc_req_t;

  typedef struct packed {
    acc_id_t id;
    data_t   data;
    logic    error;
  } acc_rsp_t;

  typedef struct packed {
    addr_t addr;
    data_t wdata;
    logic  write;
    strb_t strb;
  } dreq_t;

  typedef struct packed {
    data_t data;
    logic  error;
  } drsp_t;

endpackage

//--- rtl/core_complex.sv
`timescale 1ns/1ps

// Core complex interconnect
// Offload crossbar with the external accelerator and the stream-register
// configuration unit as targets, plus the TCDM/SoC data router
module core_complex (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  cc_pkg::addr_t    tcdm_base_i,
  // Core offload port
  input  cc_pkg::acc_req_t acc_req_i,
  input  logic             acc_req_valid_i,
  output logic             acc_req_ready_o,
  output cc_pkg::acc_rsp_t acc_rsp_o,
  output logic             acc_rsp_valid_o,
  input  logic             acc_rsp_ready_i,
  // External accelerator port
  output cc_pkg::acc_req_t acc_ext_req_o,
  output logic             acc_ext_req_valid_o,
  input  logic             acc_ext_req_ready_i,
  input  cc_pkg::acc_rsp_t acc_ext_rsp_i,
  input  logic             acc_ext_rsp_valid_i,
  output logic             acc_ext_rsp_ready_o,
  // Core data port
  input  cc_pkg::dreq_t    data_req_i,
  input  logic             data_req_valid_i,
  output logic             data_req_ready_o,
  output cc_pkg::drsp_t    data_rsp_o,
  output logic             data_rsp_valid_o,
  input  logic             data_rsp_ready_i,
  // TCDM port
  output cc_pkg::dreq_t    tcdm_req_o,
  output logic             tcdm_req_valid_o,
  input  logic             tcdm_req_ready_i,
  input  cc_pkg::drsp_t    tcdm_rsp_i,
  input  logic             tcdm_rsp_valid_i,
  output logic             tcdm_rsp_ready_o,
  // SoC port
  output cc_pkg::dreq_t    soc_req_o,
  output logic             soc_req_valid_o,
  input  logic             soc_req_ready_i,
  input  cc_pkg::drsp_t    soc_rsp_i,
  input  logic             soc_rsp_valid_i,
  output logic             soc_rsp_ready_o
);

  import cc_pkg::*;

  // Configuration unit side of the crossbar
  logic     cfg_req_valid;
  logic     cfg_req_ready;
  acc_rsp_t cfg_rsp;
  logic     cfg_rsp_valid;
  logic     cfg_rsp_ready;

  // --------------------------------------------------------------------------
  // Offload path
  // --------------------------------------------------------------------------
  // Target 0 is the external accelerator, target 1 the configuration unit
  offload_xbar u_offload_xbar (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .core_req_i       (acc_req_i),
    .core_req_valid_i (acc_req_valid_i),
    .core_req_ready_o (acc_req_ready_o),
    .core_rsp_o       (acc_rsp_o),
    .core_rsp_valid_o (acc_rsp_valid_o),
    .core_rsp_ready_i (acc_rsp_ready_i),
    .tgt_req_o        (acc_ext_req_o),
    .tgt_req_valid_o  ({cfg_req_valid, acc_ext_req_valid_o}),
    .tgt_req_ready_i  ({cfg_req_ready, acc_ext_req_ready_i}),
    .tgt_rsp_i        ({cfg_rsp, acc_ext_rsp_i}),
    .tgt_rsp_valid_i  ({cfg_rsp_valid, acc_ext_rsp_valid_i}),
    .tgt_rsp_ready_o  ({cfg_rsp_ready, acc_ext_rsp_ready_o})
  );

  // Request payload is shared, so the unit reads it from the external port
  ssr_cfg_unit u_ssr_cfg_unit (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (acc_ext_req_o),
    .req_valid_i (cfg_req_valid),
    .req_ready_o (cfg_req_ready),
    .rsp_o       (cfg_rsp),
    .rsp_valid_o (cfg_rsp_valid),
    .rsp_ready_i (cfg_rsp_ready)
  );

  // --------------------------------------------------------------------------
  // Data path
  // --------------------------------------------------------------------------
  data_router u_data_router (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .tcdm_base_i      (tcdm_base_i),
    .core_req_i       (data_req_i),
    .core_req_valid_i (data_req_valid_i),
    .core_req_ready_o (data_req_ready_o),
    .core_rsp_o       (data_rsp_o),
    .core_rsp_valid_o (data_rsp_valid_o),
    .core_rsp_ready_i (data_rsp_ready_i),
    .tcdm_req_o       (tcdm_req_o),
    .tcdm_req_valid_o (tcdm_req_valid_o),
    .tcdm_req_ready_i (tcdm_req_ready_i),
    .tcdm_rsp_i       (tcdm_rsp_i),
    .tcdm_rsp_valid_i (tcdm_rsp_valid_i),
    .tcdm_rsp_ready_o (tcdm_rsp_ready_o),
    .soc_req_o        (soc_req_o),
    .soc_req_valid_o  (soc_req_valid_o),
    .soc_req_ready_i  (soc_req_ready_i),
    .soc_rsp_i        (soc_rsp_i),
    .soc_rsp_valid_i  (soc_rsp_valid_i),
    .soc_rsp_ready_o  (soc_rsp_ready_o)
  );

endmodule

//--- rtl/data_router.sv
`timescale 1ns/1ps

// Data request router
// Sends core data requests to the TCDM or SoC port by address window and
// returns the responses in issue order through a port-order queue
module data_router (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  cc_pkg::addr_t tcdm_base_i,
  // Core side
  input  cc_pkg::dreq_t core_req_i,
  input  logic          core_req_valid_i,
  output logic          core_req_ready_o,
  output cc_pkg::drsp_t core_rsp_o,
  output logic          core_rsp_valid_o,
  input  logic          core_rsp_ready_i,
  // TCDM port
  output cc_pkg::dreq_t tcdm_req_o,
  output logic          tcdm_req_valid_o,
  input  logic          tcdm_req_ready_i,
  input  cc_pkg::drsp_t tcdm_rsp_i,
  input  logic          tcdm_rsp_valid_i,
  output logic          tcdm_rsp_ready_o,
  // SoC port
  output cc_pkg::dreq_t soc_req_o,
  output logic          soc_req_valid_o,
  input  logic          soc_req_ready_i,
  input  cc_pkg::drsp_t soc_rsp_i,
  input  logic          soc_rsp_valid_i,
  output logic          soc_rsp_ready_o
);

  import cc_pkg::*;

  port_sel_t req_sel;
  logic      push;
  logic      pop;
  logic      q_full;
  logic      q_empty;
  port_sel_t head_sel;

  // Port-order queue
  port_sel_t               order_q [RespDepth];
  logic [RespPtrWidth-1:0] wr_ptr_q;
  logic [RespPtrWidth-1:0] rd_ptr_q;
  logic [RespCntWidth-1:0] cnt_q;

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------
  // Only the bits above the naturally aligned window size count
  assign req_sel = (core_req_i.addr[AddrWidth-1:TcdmAddrWidth] ==
                    tcdm_base_i[AddrWidth-1:TcdmAddrWidth]) ? PortTcdm : PortSoc;

  // --------------------------------------------------------------------------
  // Request path
  // --------------------------------------------------------------------------
  assign q_full  = (cnt_q == RespCntWidth'(RespDepth));
  assign q_empty = (cnt_q == '0);

  assign tcdm_req_o = core_req_i;
  assign soc_req_o  = core_req_i;

  assign tcdm_req_valid_o = core_req_valid_i & ~q_full & (req_sel == PortTcdm);
  assign soc_req_valid_o  = core_req_valid_i & ~q_full & (req_sel == PortSoc);

  assign core_req_ready_o = ~q_full &
                            ((req_sel == PortTcdm) ? tcdm_req_ready_i : soc_req_ready_i);

  assign push = core_req_valid_i & core_req_ready_o;

  // --------------------------------------------------------------------------
  // Response path
  // --------------------------------------------------------------------------
  // Only the port at the head of the queue may answer
  assign head_sel = order_q[rd_ptr_q];

  assign core_rsp_o       = (head_sel == PortTcdm) ? tcdm_rsp_i : soc_rsp_i;
  assign core_rsp_valid_o = ~q_empty &
                            ((head_sel == PortTcdm) ? tcdm_rsp_valid_i : soc_rsp_valid_i);

  assign tcdm_rsp_ready_o = ~q_empty & (head_sel == PortTcdm) & core_rsp_ready_i;
  assign soc_rsp_ready_o  = ~q_empty & (head_sel == PortSoc) & core_rsp_ready_i;

  assign pop = core_rsp_valid_o & core_rsp_ready_i;

  // --------------------------------------------------------------------------
  // Queue bookkeeping
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (push) begin
      order_q[wr_ptr_q] <= req_sel;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == RespPtrWidth'(RespDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == RespPtrWidth'(RespDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

//--- rtl/offload_xbar.sv
`timescale 1ns/1ps

// Offload crossbar
// Steers core offload requests to one target by their tgt field and merges
// the target responses back with a round-robin arbiter
module offload_xbar (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Core request side
  input  cc_pkg::acc_req_t                             core_req_i,
  input  logic                                         core_req_valid_i,
  output logic                                         core_req_ready_o,
  // Core response side
  output cc_pkg::acc_rsp_t                             core_rsp_o,
  output logic                                         core_rsp_valid_o,
  input  logic                                         core_rsp_ready_i,
  // Target request side, payload shared by all targets
  output cc_pkg::acc_req_t                             tgt_req_o,
  output logic [cc_pkg::NumAccTargets-1:0]             tgt_req_valid_o,
  input  logic [cc_pkg::NumAccTargets-1:0]             tgt_req_ready_i,
  // Target response side
  input  cc_pkg::acc_rsp_t [cc_pkg::NumAccTargets-1:0] tgt_rsp_i,
  input  logic [cc_pkg::NumAccTargets-1:0]             tgt_rsp_valid_i,
  output logic [cc_pkg::NumAccTargets-1:0]             tgt_rsp_ready_o
);

  import cc_pkg::*;

  // Round-robin pointer and locked grant
  acc_tgt_t rr_q;
  acc_tgt_t grant_q;
  logic     lock_q;

  acc_tgt_t sel_idx;
  logic     sel_found;
  acc_tgt_t grant;
  logic     rsp_hs;

  // --------------------------------------------------------------------------
  // Request steering
  // --------------------------------------------------------------------------
  assign tgt_req_o        = core_req_i;
  assign core_req_ready_o = tgt_req_ready_i[core_req_i.tgt];

  always_comb begin
    tgt_req_valid_o                 = '0;
    tgt_req_valid_o[core_req_i.tgt] = core_req_valid_i;
  end

  // --------------------------------------------------------------------------
  // Response arbitration
  // --------------------------------------------------------------------------
  // First valid target at or after the pointer
  always_comb begin
    acc_tgt_t cand;
    sel_found = 1'b0;
    sel_idx   = rr_q;
    cand      = rr_q;
    for (int unsigned i = 0; i < NumAccTargets; i++) begin
      cand = acc_tgt_t'((rr_q + i) % NumAccTargets);
      if (!sel_found && tgt_rsp_valid_i[cand]) begin
        sel_found = 1'b1;
        sel_idx   = cand;
      end
    end
  end

  // A stalled response keeps its grant so the payload stays put
  assign grant            = lock_q ? grant_q : sel_idx;
  assign core_rsp_o       = tgt_rsp_i[grant];
  assign core_rsp_valid_o = tgt_rsp_valid_i[grant];
  assign rsp_hs           = core_rsp_valid_o & core_rsp_ready_i;

  always_comb begin
    tgt_rsp_ready_o        = '0;
    tgt_rsp_ready_o[grant] = core_rsp_ready_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      rr_q    <= '0;
      grant_q <= '0;
      lock_q  <= 1'b0;
    end else begin
      if (rsp_hs) begin
        // Move past the winner
        rr_q   <= acc_tgt_t'((grant + 1) % NumAccTargets);
        lock_q <= 1'b0;
      end else if (core_rsp_valid_o) begin
        grant_q <= grant;
        lock_q  <= 1'b1;
      end
    end
  end

endmodule

//--- rtl/ssr_cfg_unit.sv
`timescale 1ns/1ps

// Stream-register configuration unit
// Register file of configuration words per stream register, serving
// offloaded read and write operations with one response each
module ssr_cfg_unit (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Offload request
  input  cc_pkg::acc_req_t req_i,
  input  logic             req_valid_i,
  output logic             req_ready_o,
  // Offload response
  output cc_pkg::acc_rsp_t rsp_o,
  output logic             rsp_valid_o,
  input  logic             rsp_ready_i
);

  import cc_pkg::*;

  // Configuration words, indexed by stream register then register
  data_t cfg_q [NumSsrs][NumCfgRegs];

  cfg_addr_t             cfg_addr;
  logic [CfgRegBits-1:0] reg_sel;
  logic [CfgSsrBits-1:0] ssr_sel;
  logic                  mapped;
  data_t                 rdata;
  logic                  req_hs;
  logic                  is_write;

  acc_rsp_t rsp_q;
  logic     rsp_valid_q;

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------
  assign cfg_addr = cfg_addr_t'(req_i.argb);
  assign reg_sel  = cfg_addr[CfgRegBits+CfgSsrBits-1:CfgSsrBits];
  assign ssr_sel  = cfg_addr[CfgSsrBits-1:0];

  // Words outside the implemented space read 0 and drop writes
  assign mapped = (reg_sel < CfgRegBits'(NumCfgRegs)) &&
                  (ssr_sel < CfgSsrBits'(NumSsrs));

  assign rdata = mapped ?
                 cfg_q[ssr_sel[SsrIdxWidth-1:0]][reg_sel[CfgRegIdxWidth-1:0]] : '0;

  assign is_write = (req_i.op == CFG_WRITE);

  // --------------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------------
  // A draining response frees the single slot
  assign req_ready_o = ~rsp_valid_q | rsp_ready_i;
  assign req_hs      = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (req_hs) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Writes answer with id 0 so nothing gets written back in the core
  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      rsp_q.id    <= is_write ? '0 : req_i.id;
      rsp_q.data  <= is_write ? '0 : rdata;
      rsp_q.error <= 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // Register file
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      for (int unsigned s = 0; s < NumSsrs; s++) begin
        for (int unsigned r = 0; r < NumCfgRegs; r++) begin
          cfg_q[s][r] <= '0;
        end
      end
    end else if (req_hs && is_write && mapped) begin
      cfg_q[ssr_sel[SsrIdxWidth-1:0]][reg_sel[CfgRegIdxWidth-1:0]] <= req_i.arga;
    end
  end

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

endmodule
